/* design/cpu8_pkg.sv */
package cpu8_pkg;

  // datapath widths
  localparam int data_w  = 8;
  localparam int addr_w  = 8;
  localparam int paddr_w = 12;

  // alu operation codes
  localparam logic [3:0] op_load_a = 4'h0;
  localparam logic [3:0] op_load_b = 4'h1;
  localparam logic [3:0] op_inc    = 4'h2;
  localparam logic [3:0] op_dec    = 4'h3;
  localparam logic [3:0] op_asl    = 4'h4;
  localparam logic [3:0] op_lsr    = 4'h5;
  localparam logic [3:0] op_rol    = 4'h6;
  localparam logic [3:0] op_ror    = 4'h7;
  localparam logic [3:0] op_or     = 4'h8;
  localparam logic [3:0] op_and    = 4'h9;
  localparam logic [3:0] op_xor    = 4'ha;
  localparam logic [3:0] op_zero   = 4'hb;
  localparam logic [3:0] op_add    = 4'hc;
  localparam logic [3:0] op_sub    = 4'hd;
  localparam logic [3:0] op_adc    = 4'he;
  localparam logic [3:0] op_sbb    = 4'hf;

  // destination field of compute instructions
  localparam logic [1:0] dest_a   = 2'b00;
  localparam logic [1:0] dest_b   = 2'b01;
  localparam logic [1:0] dest_ip  = 2'b10;
  localparam logic [1:0] dest_nop = 2'b11;

  // fixed single-byte instructions
  localparam logic [7:0] insn_swap  = 8'h81;
  localparam logic [7:0] insn_clc   = 8'h88;
  localparam logic [7:0] insn_reset = 8'hbf;

  // first instruction fetched after a restart
  localparam logic [addr_w-1:0] reset_vector = 8'h80;

  // apb address map
  // 0x000..0x0ff map straight onto the memory bytes
  localparam logic [paddr_w-1:0] mem_top    = 12'h0ff;
  localparam logic [paddr_w-1:0] reg_ctrl   = 12'h100;
  localparam logic [paddr_w-1:0] reg_stores = 12'h104;

  // reg_ctrl layout
  localparam int ctrl_run_bit = 0;

endpackage

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [cpu8_pkg::data_w-1:0] a,
  input  logic [cpu8_pkg::data_w-1:0] b,
  input  logic [3:0]                  aluop,
  input  logic                        carry,
  output logic [cpu8_pkg::data_w:0]   y
);
  import cpu8_pkg::*;

  logic [data_w:0] a_x;
  logic [data_w:0] b_x;
  logic [data_w:0] c_x;

  // zero-extended operands, bit 8 catches carry or borrow
  assign a_x = {1'b0, a};
  assign b_x = {1'b0, b};
  assign c_x = {{data_w{1'b0}}, carry};

  always_comb begin
    case (aluop)
      op_load_a: y = a_x;
      op_load_b: y = b_x;
      op_inc:    y = a_x + 9'd1;
      op_dec:    y = a_x - 9'd1;
      // shifts and rotates, outgoing bit lands in y[8]
      op_asl:    y = {a, 1'b0};
      op_lsr:    y = {a[0], 1'b0, a[data_w-1:1]};
      op_rol:    y = {a, carry};
      op_ror:    y = {a[0], carry, a[data_w-1:1]};
      op_or:     y = {1'b0, a | b};
      op_and:    y = {1'b0, a & b};
      op_xor:    y = {1'b0, a ^ b};
      op_zero:   y = '0;
      op_add:    y = a_x + b_x;
      op_sub:    y = a_x - b_x;
      // carry and borrow chained in from the flag
      op_adc:    y = a_x + b_x + c_x;
      op_sbb:    y = a_x - b_x - c_x;
      default:   y = '0;
    endcase
  end

endmodule

/* design/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        run,
  input  logic [cpu8_pkg::data_w-1:0] mem_rdata,
  output logic [cpu8_pkg::addr_w-1:0] mem_addr,
  output logic [cpu8_pkg::data_w-1:0] mem_wdata,
  output logic                        mem_we
);
  import cpu8_pkg::*;

  typedef enum logic [2:0] {
    st_reset,
    st_select,
    st_decode,
    st_compute,
    st_read_ip
  } state_t;

  state_t            state;
  logic [addr_w-1:0] ip;
  logic [data_w-1:0] a;
  logic [data_w-1:0] b;
  logic [data_w-1:0] opcode;
  logic [data_w-1:0] alu_b;
  logic [data_w:0]   y;
  logic              carry;
  logic              zero;
  logic              write_q;
  logic              branch_taken;
  logic [3:0]        aluop;
  logic [1:0]        opdest;

  assign aluop  = opcode[3:0];
  assign opdest = opcode[5:4];

  // immediate and read [B] forms take the operand from memory
  assign alu_b = opcode[6] ? mem_rdata : b;

  // branch test on the opcode byte being decoded
  assign branch_taken = (mem_rdata[0] && (mem_rdata[1] == carry)) ||
                        (mem_rdata[2] && (mem_rdata[3] == zero));

  // a pending store is dropped once the host stops the core
  assign mem_we = write_q & run;

  alu u_alu (
    .a     (a),
    .b     (alu_b),
    .aluop (aluop),
    .carry (carry),
    .y     (y)
  );

  always_ff @(posedge clk) begin
    if (reset || !run) begin
      state   <= st_reset;
      write_q <= 1'b0;
      carry   <= 1'b0;
      zero    <= 1'b0;
    end else begin
      case (state)
        st_reset: begin
          ip      <= reset_vector;
          write_q <= 1'b0;
          state   <= st_select;
        end
        st_select: begin
          mem_addr <= ip;
          ip       <= ip + 8'd1;
          write_q  <= 1'b0;
          state    <= st_decode;
        end
        st_decode: begin
          opcode <= mem_rdata;
          casez (mem_rdata)
            8'b00??????: begin
              state <= st_compute;
            end
            // immediate operand is the next byte
            8'b01??????: begin
              mem_addr <= ip;
              ip       <= ip + 8'd1;
              state    <= st_compute;
            end
            8'b11??????: begin
              mem_addr <= b;
              state    <= st_compute;
            end
            // store A into the low 16 bytes
            8'b1001????: begin
              mem_addr  <= {4'b0000, mem_rdata[3:0]};
              mem_wdata <= a;
              write_q   <= 1'b1;
              state     <= st_select;
            end
            insn_clc: begin
              carry <= 1'b0;
              state <= st_select;
            end
            insn_swap: begin
              a     <= b;
              b     <= a;
              state <= st_select;
            end
            8'b1010????: begin
              if (branch_taken) begin
                mem_addr <= ip;
                state    <= st_read_ip;
              end else begin
                state <= st_select;
              end
              // step over the target byte either way
              ip <= ip + 8'd1;
            end
            default: begin
              state <= st_reset;
            end
          endcase
        end
        st_compute: begin
          case (opdest)
            dest_a:   a  <= y[data_w-1:0];
            dest_b:   b  <= y[data_w-1:0];
            dest_ip:  ip <= y[data_w-1:0];
            dest_nop: ;
            default:  ;
          endcase
          // only shift and arithmetic groups touch carry
          if (aluop[2]) begin
            carry <= y[data_w];
          end
          zero  <= ~|y[data_w-1:0];
          state <= st_select;
        end
        st_read_ip: begin
          ip    <= mem_rdata;
          state <= st_select;
        end
        default: begin
          state <= st_reset;
        end
      endcase
    end
  end

endmodule

/* design/code_mem.sv */
`timescale 1ns/1ps

module code_mem (
  input  logic                        clk,
  // processor port
  input  logic [cpu8_pkg::addr_w-1:0] mem_addr,
  input  logic [cpu8_pkg::data_w-1:0] mem_wdata,
  input  logic                        mem_we,
  output logic [cpu8_pkg::data_w-1:0] mem_rdata,
  // host port
  input  logic [cpu8_pkg::addr_w-1:0] host_addr,
  input  logic [cpu8_pkg::data_w-1:0] host_wdata,
  input  logic                        host_we,
  output logic [cpu8_pkg::data_w-1:0] host_rdata
);
  import cpu8_pkg::*;

  logic [data_w-1:0] mem [2**addr_w];

  // both read ports answer in the same cycle
  assign mem_rdata  = mem[mem_addr];
  assign host_rdata = mem[host_addr];

  // host writes only land while the core is stopped
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end else if (host_we) begin
      mem[host_addr] <= host_wdata;
    end
  end

endmodule

/* design/apb_host_port.sv */
`timescale 1ns/1ps

module apb_host_port (
  input  logic                         clk,
  input  logic                         reset,
  // apb slave
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [cpu8_pkg::paddr_w-1:0] paddr,
  input  logic [cpu8_pkg::data_w-1:0]  pwdata,
  output logic [cpu8_pkg::data_w-1:0]  prdata,
  output logic                         pready,
  output logic                         pslverr,
  // store watch and memory host port
  input  logic                         mem_we,
  input  logic [cpu8_pkg::data_w-1:0]  host_rdata,
  output logic                         run,
  output logic [cpu8_pkg::addr_w-1:0]  host_addr,
  output logic [cpu8_pkg::data_w-1:0]  host_wdata,
  output logic                         host_we
);
  import cpu8_pkg::*;

  logic              access;
  logic              is_mem;
  logic              is_ctrl;
  logic              is_stores;
  logic              refused;
  logic              ctrl_wr;
  logic [data_w-1:0] store_count;

  assign access    = psel & penable;
  assign is_mem    = (paddr <= mem_top);
  assign is_ctrl   = (paddr == reg_ctrl);
  assign is_stores = (paddr == reg_stores);

  // memory is locked while running, anything unmapped errors
  assign refused = (is_mem & run) | ~(is_mem | is_ctrl | is_stores);

  // no wait states
  assign pready  = 1'b1;
  assign pslverr = access & refused;

  assign ctrl_wr = access & pwrite & is_ctrl;

  assign host_addr  = paddr[addr_w-1:0];
  assign host_wdata = pwdata;
  assign host_we    = access & pwrite & is_mem & ~run;

  always_comb begin
    prdata = '0;
    if (!refused) begin
      if (is_mem) begin
        prdata = host_rdata;
      end else if (is_ctrl) begin
        prdata[ctrl_run_bit] = run;
      end else begin
        prdata = store_count;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      run         <= 1'b0;
      store_count <= '0;
    end else begin
      if (ctrl_wr) begin
        run <= pwdata[ctrl_run_bit];
      end
      // starting a run restarts the count
      if (ctrl_wr && pwdata[ctrl_run_bit]) begin
        store_count <= '0;
      end else if (mem_we) begin
        store_count <= store_count + 8'd1;
      end
    end
  end

endmodule

/* design/cpu8_top.sv */
`timescale 1ns/1ps

module cpu8_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [cpu8_pkg::paddr_w-1:0] paddr,
  input  logic [cpu8_pkg::data_w-1:0]  pwdata,
  output logic [cpu8_pkg::data_w-1:0]  prdata,
  output logic                         pready,
  output logic                         pslverr
);

  logic                        run;
  logic [cpu8_pkg::addr_w-1:0] mem_addr;
  logic [cpu8_pkg::data_w-1:0] mem_wdata;
  logic [cpu8_pkg::data_w-1:0] mem_rdata;
  logic                        mem_we;
  logic [cpu8_pkg::addr_w-1:0] host_addr;
  logic [cpu8_pkg::data_w-1:0] host_wdata;
  logic [cpu8_pkg::data_w-1:0] host_rdata;
  logic                        host_we;

  apb_host_port u_host (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .mem_we     (mem_we),
    .host_rdata (host_rdata),
    .run        (run),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_we    (host_we)
  );

  cpu_core u_core (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we)
  );

  code_mem u_mem (
    .clk        (clk),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_we     (mem_we),
    .mem_rdata  (mem_rdata),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_we    (host_we),
    .host_rdata (host_rdata)
  );

endmodule

/* test/cpu8_props.sv */
`timescale 1ns/1ps

module cpu8_props (
  input logic clk,
  input logic reset,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic run,
  input logic host_we,
  input logic mem_we
);

  // no wait states on any access
  a_pready_access: assert property (
    @(posedge clk) disable iff (reset) (psel && penable) |-> pready
  ) else $error("pready low during an access phase");

  a_pslverr_phase: assert property (
    @(posedge clk) disable iff (reset) pslverr |-> (psel && penable)
  ) else $error("pslverr raised outside an access phase");

  // host and core never share the write port
  a_host_we_idle: assert property (
    @(posedge clk) disable iff (reset) run |-> !host_we
  ) else $error("host write to memory while the core runs");

  a_mem_we_run: assert property (
    @(posedge clk) disable iff (reset) !run |-> !mem_we
  ) else $error("core store while the core is stopped");

endmodule

bind apb_host_port cpu8_props u_props (
  .clk     (clk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .run     (run),
  .host_we (host_we),
  .mem_we  (mem_we)
);

/* test/cpu8_tb.sv */
`timescale 1ns/1ps

module cpu8_tb;
  import cpu8_pkg::*;

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [7:0]  pwdata;
  logic [7:0]  prdata;
  logic        pready;
  logic        pslverr;

  logic [7:0] shadow [256];
  logic [7:0] mm [256];
  logic [7:0] prog [$];
  logic [7:0] rd_data;
  logic       rd_err;
  int         seed = 32'hff92_af86;

  cpu8_top dut (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #2 clk = ~clk;

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s", what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
    assert (exp === got) else begin
      $display("Fail %s: expected %02h, actual %02h", name, exp, got);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  // setup phase, access phase, sample mid-cycle once pready is up
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [7:0] data);
    int n;
    n = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      n++;
      if (n > 16) timed_out("pready");
      @(negedge clk);
    end
    rd_data = prdata;
    rd_err  = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic write_mem(input logic [7:0] addr, input logic [7:0] data);
    apb_access(1'b1, {4'h0, addr}, data);
    check_value("mem write error", 8'h00, {7'd0, rd_err});
    shadow[addr] = data;
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      write_mem(8'(8'h80 + i), prog[i]);
    end
  endtask

  // poll the store counter until the program has made its stores
  task automatic wait_stores(input logic [7:0] target);
    int polls;
    polls = 0;
    apb_access(1'b0, reg_stores, 8'h00);
    while (rd_data < target) begin
      polls++;
      if (polls > 4000) timed_out("the store count");
      apb_access(1'b0, reg_stores, 8'h00);
    end
  endtask

  function automatic logic [8:0] ref_alu(input logic [3:0] op, input logic [7:0] x,
                                         input logic [7:0] v, input logic c);
    logic [8:0] xe;
    logic [8:0] ve;
    logic [8:0] ce;
    xe = {1'b0, x};
    ve = {1'b0, v};
    ce = {8'd0, c};
    case (op)
      4'd0:  return xe;
      4'd1:  return ve;
      4'd2:  return xe + 9'd1;
      4'd3:  return xe - 9'd1;
      4'd4:  return {x, 1'b0};
      4'd5:  return {x[0], 1'b0, x[7:1]};
      4'd6:  return {x, c};
      4'd7:  return {x[0], c, x[7:1]};
      4'd8:  return ve | xe;
      4'd9:  return ve & xe;
      4'd10: return ve ^ xe;
      4'd11: return 9'd0;
      4'd12: return xe + ve;
      4'd13: return xe - ve;
      4'd14: return xe + ve + ce;
      default: return xe - ve - ce;
    endcase
  endfunction

  // instruction-level model on mm that stops after the given store count
  task automatic run_model(input int target);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] ip;
    logic [7:0] op;
    logic [7:0] opnd;
    logic [7:0] tmp;
    logic [8:0] y;
    logic       c;
    logic       z;
    int         stores;
    int         steps;
    a = 8'h00;
    b = 8'h00;
    ip = reset_vector;
    c = 1'b0;
    z = 1'b0;
    stores = 0;
    steps = 0;
    while (stores < target) begin
      steps++;
      if (steps > 100000) timed_out("the model to finish");
      op = mm[ip];
      ip = ip + 8'd1;
      if (op[7:6] != 2'b10) begin
        if (op[7:6] == 2'b00) begin
          opnd = b;
        end else if (op[7:6] == 2'b01) begin
          opnd = mm[ip];
          ip = ip + 8'd1;
        end else begin
          opnd = mm[b];
        end
        y = ref_alu(op[3:0], a, opnd, c);
        case (op[5:4])
          2'b00: a = y[7:0];
          2'b01: b = y[7:0];
          2'b10: ip = y[7:0];
          default: ;
        endcase
        if (op[2]) c = y[8];
        z = (y[7:0] == 8'h00);
      end else if (op[7:4] == 4'h9) begin
        mm[{4'h0, op[3:0]}] = a;
        stores++;
      end else if (op == insn_clc) begin
        c = 1'b0;
      end else if (op == insn_swap) begin
        tmp = a;
        a = b;
        b = tmp;
      end else if (op[7:4] == 4'ha) begin
        tmp = mm[ip];
        ip = ip + 8'd1;
        if ((op[0] && op[1] == c) || (op[2] && op[3] == z)) ip = tmp;
      end else begin
        ip = reset_vector;
      end
    end
  endtask

  // load, model, run until the target store count, stop, compare low bytes
  task automatic run_program(input string name, input int target);
    load_program();
    mm = shadow;
    run_model(target);
    apb_access(1'b1, reg_ctrl, 8'h01);
    wait_stores(8'(target));
    apb_access(1'b1, reg_ctrl, 8'h00);
    for (int i = 0; i < 16; i++) begin
      apb_access(1'b0, 12'(i), 8'h00);
      check_value(name, mm[i], rd_data);
    end
    shadow = mm;
  endtask

  initial begin
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] rs;
    clk = 1'b0;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // register reset values
    apb_access(1'b0, reg_ctrl, 8'h00);
    check_value("reset ctrl", 8'h00, rd_data);
    check_value("reset ctrl err", 8'h00, {7'd0, rd_err});
    apb_access(1'b0, reg_stores, 8'h00);
    check_value("reset stores", 8'h00, rd_data);
    check_value("reset stores err", 8'h00, {7'd0, rd_err});

    // fill then random write and read back
    for (int i = 0; i < 256; i++) begin
      write_mem(8'(i), 8'(i * 37) ^ 8'h5a);
    end
    for (int i = 0; i < 24; i++) begin
      addr = 8'($random(seed));
      data = 8'($random(seed));
      write_mem(addr, data);
      apb_access(1'b0, {4'h0, addr}, 8'h00);
      check_value("mem readback", data, rd_data);
    end

    // every alu op on random immediates with each result stored to [op]
    prog.delete();
    for (int k = 0; k < 16; k++) begin
      prog.push_back(8'h41);
      prog.push_back(8'($random(seed)));
      prog.push_back({4'h4, 4'(k)});
      prog.push_back(8'($random(seed)));
      prog.push_back({4'h9, 4'(k)});
    end
    prog.push_back(8'h61);
    prog.push_back(8'(8'h80 + prog.size() - 1));
    run_program("alu ops", 16);
    apb_access(1'b0, reg_stores, 8'h00);
    check_value("alu ops count", 8'd16, rd_data);

    // add a step until carry out and store the wrapped count
    rs = 8'($random(seed)) | 8'h01;
    prog = '{8'h41, rs, 8'h51, 8'h00, 8'h88, 8'h81, 8'h0e, 8'h81,
             8'ha1, 8'h84, 8'h81, 8'h90, 8'h61, 8'h8c};
    run_program("counting", 1);
    apb_access(1'b0, reg_stores, 8'h00);
    check_value("counting count", 8'd1, rd_data);

    // read [B] and zero branches, then a restart through a bad opcode
    // one pass makes two stores, so four need the restart at 0x80
    write_mem(8'h20, 8'($random(seed)));
    prog = '{8'h51, 8'h20, 8'hc1, 8'h90, 8'h4b, 8'h00, 8'hac, 8'h89,
             8'h91, 8'h41, 8'h05, 8'hac, 8'h80, 8'h92, 8'h8f};
    run_program("restart", 4);

    // refused accesses while running
    write_mem(8'h80, 8'h61);
    write_mem(8'h81, 8'h80);
    apb_access(1'b1, reg_ctrl, 8'h01);
    apb_access(1'b0, reg_ctrl, 8'h00);
    check_value("run readback", 8'h01, rd_data);
    apb_access(1'b1, 12'h003, ~shadow[3]);
    check_value("busy write err", 8'h01, {7'd0, rd_err});
    apb_access(1'b0, 12'h005, 8'h00);
    check_value("busy read err", 8'h01, {7'd0, rd_err});
    check_value("busy read data", 8'h00, rd_data);
    apb_access(1'b0, 12'h108, 8'h00);
    check_value("unmapped read err", 8'h01, {7'd0, rd_err});
    check_value("unmapped read data", 8'h00, rd_data);
    apb_access(1'b1, 12'h108, 8'h55);
    check_value("unmapped write err", 8'h01, {7'd0, rd_err});
    apb_access(1'b1, reg_ctrl, 8'h00);
    apb_access(1'b0, 12'h003, 8'h00);
    check_value("mem after refusal", shadow[3], rd_data);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* compile.f */
design/cpu8_pkg.sv
design/alu.sv
design/cpu_core.sv
design/code_mem.sv
design/apb_host_port.sv
design/cpu8_top.sv
test/cpu8_props.sv
test/cpu8_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpu8_tb
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
